//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

	// basic widths
	typedef logic [63:0] u64;
	typedef logic [31:0] u32;
	typedef u32 instr_t;
	typedef logic [4:0] reg_addr_t;

	// shared by fetch, data and external requesters
	typedef struct packed {
		logic valid;
		logic write;
		u64   addr;
		u64   data;
	} bus_req_t;

	typedef struct packed {
		logic data_ok;
		u64   data;
	} bus_resp_t;

	// one retired instruction that wrote a register
	typedef struct packed {
		logic      valid;
		u64        pc;
		reg_addr_t rd;
		u64        data;
	} commit_t;

	// result of decoding and executing one instruction
	typedef struct packed {
		u64        result;
		u64        next_pc;
		reg_addr_t rd;
		logic      reg_write;
		logic      is_load;
		logic      is_store;
		u64        store_data;
		logic      halt;
	} exec_out_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_EXEC,
		S_MEM,
		S_WB,
		S_HALT
	} core_state_t;

endpackage

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic              clk,
	input  logic              reset,
	input  core_pkg::reg_addr_t ra1,
	input  core_pkg::reg_addr_t ra2,
	output core_pkg::u64      rd1,
	output core_pkg::u64      rd2,
	input  logic              we,
	input  core_pkg::reg_addr_t wa,
	input  core_pkg::u64      wd
);

	core_pkg::u64 regs [32];

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	// x0 is cleared on reset and never written afterwards
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  core_pkg::instr_t    instr,
	input  core_pkg::u64        pc,
	input  core_pkg::u64        rs1_val,
	input  core_pkg::u64        rs2_val,
	output core_pkg::exec_out_t out
);

	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_LUI = 7'b0110111;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	core_pkg::u64 imm_i;
	core_pkg::u64 imm_s;
	core_pkg::u64 imm_b;
	core_pkg::u64 imm_j;
	core_pkg::u64 imm_u;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

	always_comb begin
		out.result = '0;
		out.next_pc = pc + 64'd4;
		out.rd = instr[11:7];
		out.reg_write = 1'b0;
		out.is_load = 1'b0;
		out.is_store = 1'b0;
		out.store_data = rs2_val;
		out.halt = 1'b0;
		case (opcode)
			OP_IMM: begin
				out.result = rs1_val + imm_i;
				out.reg_write = (funct3 == 3'b000);
				out.halt = (funct3 != 3'b000);
			end
			OP_REG: begin
				out.reg_write = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: out.result = rs1_val + rs2_val;
					10'b0100000_000: out.result = rs1_val - rs2_val;
					10'b0000000_111: out.result = rs1_val & rs2_val;
					10'b0000000_110: out.result = rs1_val | rs2_val;
					default: begin
						out.reg_write = 1'b0;
						out.halt = 1'b1;
					end
				endcase
			end
			OP_LOAD: begin
				// ld only, the result holds the address until the data returns
				out.result = rs1_val + imm_i;
				out.is_load = (funct3 == 3'b011);
				out.reg_write = (funct3 == 3'b011);
				out.halt = (funct3 != 3'b011);
			end
			OP_STORE: begin
				out.result = rs1_val + imm_s;
				out.is_store = (funct3 == 3'b011);
				out.halt = (funct3 != 3'b011);
			end
			OP_BRANCH: begin
				if (funct3 != 3'b000) begin
					out.halt = 1'b1;
				end else if (rs1_val == rs2_val) begin
					out.next_pc = pc + imm_b;
				end
			end
			OP_JAL: begin
				out.result = pc + 64'd4;
				out.next_pc = pc + imm_j;
				out.reg_write = 1'b1;
			end
			OP_LUI: begin
				out.result = imm_u;
				out.reg_write = 1'b1;
			end
			// ebreak lands here along with every unknown opcode
			default: out.halt = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/core.sv
`timescale 1ns/1ps
`default_nettype none

module core (
	input  logic                clk,
	input  logic                reset,
	input  logic                run,
	output core_pkg::bus_req_t  ireq,
	input  core_pkg::bus_resp_t iresp,
	output core_pkg::bus_req_t  dreq,
	input  core_pkg::bus_resp_t dresp,
	output core_pkg::commit_t   commit,
	output logic                halted
);

	core_pkg::core_state_t state;
	core_pkg::u64 pc;
	core_pkg::instr_t instr_q;
	core_pkg::exec_out_t ex_out;
	core_pkg::exec_out_t ex_q;
	core_pkg::u64 rs1_val;
	core_pkg::u64 rs2_val;
	logic rf_we;

	assign rf_we = (state == core_pkg::S_WB) && ex_q.reg_write;

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.ra1(instr_q[19:15]),
		.ra2(instr_q[24:20]),
		.rd1(rs1_val),
		.rd2(rs2_val),
		.we(rf_we),
		.wa(ex_q.rd),
		.wd(ex_q.result)
	);

	exec_unit u_exec_unit (
		.instr(instr_q),
		.pc(pc),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.out(ex_out)
	);

	assign ireq.valid = (state == core_pkg::S_FETCH);
	assign ireq.write = 1'b0;
	assign ireq.addr = pc;
	assign ireq.data = '0;

	assign dreq.valid = (state == core_pkg::S_MEM);
	assign dreq.write = ex_q.is_store;
	assign dreq.addr = ex_q.result;
	assign dreq.data = ex_q.store_data;

	assign commit.valid = rf_we;
	assign commit.pc = pc;
	assign commit.rd = ex_q.rd;
	assign commit.data = ex_q.result;

	assign halted = (state == core_pkg::S_HALT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= core_pkg::S_IDLE;
			pc <= '0;
		end else begin
			case (state)
				core_pkg::S_IDLE: begin
					pc <= '0;
					if (run) state <= core_pkg::S_FETCH;
				end
				core_pkg::S_FETCH: begin
					if (iresp.data_ok) state <= core_pkg::S_EXEC;
				end
				core_pkg::S_EXEC: begin
					if (ex_out.halt) state <= core_pkg::S_HALT;
					else if (ex_out.is_load || ex_out.is_store) state <= core_pkg::S_MEM;
					else state <= core_pkg::S_WB;
				end
				core_pkg::S_MEM: begin
					if (dresp.data_ok) state <= core_pkg::S_WB;
				end
				core_pkg::S_WB: begin
					pc <= ex_q.next_pc;
					state <= run ? core_pkg::S_FETCH : core_pkg::S_IDLE;
				end
				default: begin
					if (!run) state <= core_pkg::S_IDLE;
				end
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		// memory words hold two instructions, pc bit 2 picks the upper one
		if (state == core_pkg::S_FETCH && iresp.data_ok) begin
			instr_q <= pc[2] ? iresp.data[63:32] : iresp.data[31:0];
		end
		if (state == core_pkg::S_EXEC) begin
			ex_q <= ex_out;
		end else if (state == core_pkg::S_MEM && dresp.data_ok && ex_q.is_load) begin
			ex_q.result <= dresp.data;
		end
	end

	// a request stays up and unchanged until its data_ok
	a_dreq_held: assert property (@(posedge clk) disable iff (reset)
		dreq.valid && !dresp.data_ok |=> dreq.valid && $stable(dreq));
	a_ireq_held: assert property (@(posedge clk) disable iff (reset)
		ireq.valid && !iresp.data_ok |=> ireq.valid && $stable(ireq));

endmodule

`default_nettype wire

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  logic                clk,
	input  logic                reset,
	input  core_pkg::bus_req_t  ext_req,
	output core_pkg::bus_resp_t ext_resp,
	input  core_pkg::bus_req_t  dreq,
	output core_pkg::bus_resp_t dresp,
	input  core_pkg::bus_req_t  ireq,
	output core_pkg::bus_resp_t iresp,
	output core_pkg::bus_req_t  mem_req,
	input  core_pkg::bus_resp_t mem_resp
);

	// one-hot owner of the outstanding request, ext/data/instr
	logic [2:0] pend;
	logic [2:0] grant;
	logic busy;

	assign busy = |pend;

	always_comb begin
		grant = 3'b000;
		if (!busy) begin
			if (ext_req.valid) grant = 3'b100;
			else if (dreq.valid) grant = 3'b010;
			else if (ireq.valid) grant = 3'b001;
		end
	end

	always_comb begin
		if (grant[2]) mem_req = ext_req;
		else if (grant[1]) mem_req = dreq;
		else mem_req = ireq;
		mem_req.valid = |grant;
	end

	// a response cycle always frees the bus, so pend only lives one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			pend <= 3'b000;
		end else begin
			pend <= grant;
		end
	end

	assign ext_resp.data_ok = pend[2] & mem_resp.data_ok;
	assign dresp.data_ok = pend[1] & mem_resp.data_ok;
	assign iresp.data_ok = pend[0] & mem_resp.data_ok;
	assign ext_resp.data = mem_resp.data;
	assign dresp.data = mem_resp.data;
	assign iresp.data = mem_resp.data;

	a_one_resp: assert property (@(posedge clk) disable iff (reset)
		mem_resp.data_ok |-> $onehot({ext_resp.data_ok, dresp.data_ok, iresp.data_ok}));
	a_no_req_when_busy: assert property (@(posedge clk) disable iff (reset)
		busy |-> !mem_req.valid && mem_resp.data_ok);

endmodule

`default_nettype wire

//--- logic/sram.sv
`timescale 1ns/1ps
`default_nettype none

module sram #(
	parameter int MEM_WORDS = 512
) (
	input  logic                clk,
	input  core_pkg::bus_req_t  req,
	output core_pkg::bus_resp_t resp
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	core_pkg::u64 mem [MEM_WORDS];
	logic [IDX_W-1:0] idx;
	core_pkg::u64 rdata_q;
	logic data_ok_q;

	// word address, the low three bits select a byte inside the word
	assign idx = req.addr[IDX_W+2:3];

	always_ff @(posedge clk) begin
		if (req.valid && req.write) begin
			mem[idx] <= req.data;
		end
	end

	always_ff @(posedge clk) begin
		if (req.valid) begin
			rdata_q <= mem[idx];
		end
	end

	// every accepted request is answered in the next cycle
	always_ff @(posedge clk) begin
		data_ok_q <= req.valid;
	end

	assign resp.data_ok = data_ok_q;
	assign resp.data = rdata_q;

endmodule

`default_nettype wire

//--- logic/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
	parameter int MEM_WORDS = 512
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                run,
	input  core_pkg::bus_req_t  ext_req,
	output core_pkg::bus_resp_t ext_resp,
	output core_pkg::commit_t   commit,
	output logic                halted
);

	core_pkg::bus_req_t ireq;
	core_pkg::bus_req_t dreq;
	core_pkg::bus_req_t mem_req;
	core_pkg::bus_resp_t iresp;
	core_pkg::bus_resp_t dresp;
	core_pkg::bus_resp_t mem_resp;

	core u_core (
		.clk(clk),
		.reset(reset),
		.run(run),
		.ireq(ireq),
		.iresp(iresp),
		.dreq(dreq),
		.dresp(dresp),
		.commit(commit),
		.halted(halted)
	);

	bus_arbiter u_bus_arbiter (
		.clk(clk),
		.reset(reset),
		.ext_req(ext_req),
		.ext_resp(ext_resp),
		.dreq(dreq),
		.dresp(dresp),
		.ireq(ireq),
		.iresp(iresp),
		.mem_req(mem_req),
		.mem_resp(mem_resp)
	);

	sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
		.clk(clk),
		.req(mem_req),
		.resp(mem_resp)
	);

endmodule

`default_nettype wire

//--- sim/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	localparam int CYCLE_LIMIT = 20000;
	localparam logic [6:0] IMM_OP = 7'b0010011;
	localparam logic [6:0] LOAD_OP = 7'b0000011;
	localparam core_pkg::instr_t EBREAK = 32'h0010_0073;

	logic clk;
	logic reset;
	logic run;
	core_pkg::bus_req_t ext_req;
	core_pkg::bus_resp_t ext_resp;
	core_pkg::commit_t commit;
	logic halted;

	integer seed = 32'h3b23;
	int cycles = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	core_pkg::instr_t prog[$];
	core_pkg::commit_t got_q[$];
	core_pkg::commit_t exp_q[$];

	soc_top #(.MEM_WORDS(512)) dut0 (
		.clk(clk),
		.reset(reset),
		.run(run),
		.ext_req(ext_req),
		.ext_resp(ext_resp),
		.commit(commit),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// commit is combinational from the core state, stable at the falling edge
	always @(negedge clk) begin
		if (!reset && commit.valid) got_q.push_back(commit);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: core never halted within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	// rv64i instruction encodings
	function automatic core_pkg::instr_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic core_pkg::instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic core_pkg::instr_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
	endfunction

	function automatic core_pkg::instr_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic core_pkg::instr_t j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic core_pkg::instr_t u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic core_pkg::u64 sext12(input logic [11:0] v);
		return {{52{v[11]}}, v};
	endfunction

	function automatic void expect_commit(input core_pkg::u64 pc, input core_pkg::reg_addr_t rd,
			input core_pkg::u64 data);
		core_pkg::commit_t c;
		c.valid = 1'b1;
		c.pc = pc;
		c.rd = rd;
		c.data = data;
		exp_q.push_back(c);
	endfunction

	function automatic string commit_text(input core_pkg::commit_t c);
		return $sformatf("pc %h rd %0d data %h", c.pc, c.rd, c.data);
	endfunction

	function automatic void new_test();
		prog.delete();
		exp_q.delete();
		test_errors = 0;
	endfunction

	task automatic ext_access(input logic write, input core_pkg::u64 addr,
			input core_pkg::u64 wdata, output core_pkg::u64 rdata);
		ext_req.valid = 1'b1;
		ext_req.write = write;
		ext_req.addr = addr;
		ext_req.data = wdata;
		do @(negedge clk); while (!ext_resp.data_ok);
		rdata = ext_resp.data;
		ext_req = '0;
	endtask

	// two instructions per word, the lower address in the low half
	task automatic load_program;
		core_pkg::u64 word;
		core_pkg::u64 unused;
		for (int i = 0; i < prog.size(); i += 2) begin
			word[31:0] = prog[i];
			word[63:32] = (i + 1 < prog.size()) ? prog[i + 1] : 32'h0;
			ext_access(1'b1, 64'(i * 4), word, unused);
		end
	endtask

	task automatic run_program;
		got_q.delete();
		run = 1'b1;
		while (!halted) @(negedge clk);
		// stay a while to catch any commit after the halt
		repeat (5) @(negedge clk);
		if (!halted) begin
			$display("halted dropped while run was still high");
			test_errors++;
		end
		run = 1'b0;
		while (halted) @(negedge clk);
	endtask

	task automatic check_value(input string name, input core_pkg::u64 expected,
			input core_pkg::u64 actual);
		if (expected != actual) begin
			$display("error %s: expected %h actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_commits(input string name);
		int n;
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		if (got_q.size() != exp_q.size()) begin
			$display("error %s: commit count expected %0d actual %0d", name,
				exp_q.size(), got_q.size());
			test_errors++;
		end
		for (int i = 0; i < n; i++) begin
			if (got_q[i] != exp_q[i]) begin
				$display("error %s: commit %0d expected %s actual %s", name, i,
					commit_text(exp_q[i]), commit_text(got_q[i]));
				test_errors++;
			end
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errors);
		end
	endtask

	task automatic test_arith;
		logic [19:0] a;
		logic [11:0] b;
		logic [11:0] c;
		core_pkg::u64 x1;
		core_pkg::u64 x2;
		new_test();
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		x1 = {{32{a[19]}}, a, 12'h000};
		expect_commit(0, 1, x1);
		x1 = x1 + sext12(b);
		x2 = sext12(c);
		expect_commit(4, 1, x1);
		expect_commit(8, 2, x2);
		expect_commit(12, 3, x1 + x2);
		expect_commit(16, 4, x1 - x2);
		expect_commit(20, 5, x1 & x2);
		expect_commit(24, 6, x1 | x2);
		prog = '{u_type(a, 1), i_type(b, 1, 3'b000, 1, IMM_OP), i_type(c, 0, 3'b000, 2, IMM_OP),
			r_type(7'h00, 2, 1, 3'b000, 3), r_type(7'h20, 2, 1, 3'b000, 4),
			r_type(7'h00, 2, 1, 3'b111, 5), r_type(7'h00, 2, 1, 3'b110, 6), EBREAK};
		load_program();
		run_program();
		compare_commits("arith");
		end_test("arith");
	endtask

	task automatic test_memory;
		logic [19:0] a;
		logic [11:0] b;
		core_pkg::u64 v;
		core_pkg::u64 pre;
		core_pkg::u64 rd_v;
		new_test();
		a = $random(seed);
		b = $random(seed);
		pre = {$random(seed), $random(seed)};
		v = {{32{a[19]}}, a, 12'h000};
		expect_commit(0, 1, 64'h400);
		expect_commit(4, 2, v);
		v = v + sext12(b);
		expect_commit(8, 2, v);
		expect_commit(16, 3, v);
		expect_commit(20, 4, pre);
		prog = '{i_type(12'h400, 0, 3'b000, 1, IMM_OP), u_type(a, 2),
			i_type(b, 2, 3'b000, 2, IMM_OP), s_type(12'd8, 2, 1),
			i_type(12'd8, 1, 3'b011, 3, LOAD_OP), i_type(12'd0, 1, 3'b011, 4, LOAD_OP), EBREAK};
		load_program();
		ext_access(1'b1, 64'h400, pre, rd_v);
		run_program();
		compare_commits("memory");
		ext_access(1'b0, 64'h408, '0, rd_v);
		check_value("memory readback", v, rd_v);
		end_test("memory");
	endtask

	task automatic test_control;
		new_test();
		// taken beq skips pc 12, untaken beq falls through, jal lands on pc 40
		prog = '{i_type(12'd5, 0, 3'b000, 1, IMM_OP), i_type(12'd5, 0, 3'b000, 2, IMM_OP),
			b_type(13'd8, 2, 1), i_type(12'd1, 0, 3'b000, 3, IMM_OP),
			i_type(12'd2, 0, 3'b000, 4, IMM_OP), b_type(13'd8, 0, 1),
			i_type(12'd3, 0, 3'b000, 5, IMM_OP), j_type(21'd12, 6),
			i_type(12'd9, 0, 3'b000, 7, IMM_OP), i_type(12'd9, 0, 3'b000, 7, IMM_OP),
			i_type(12'd4, 0, 3'b000, 8, IMM_OP), EBREAK};
		expect_commit(0, 1, 5);
		expect_commit(4, 2, 5);
		expect_commit(16, 4, 2);
		expect_commit(24, 5, 3);
		expect_commit(28, 6, 32);
		expect_commit(40, 8, 4);
		load_program();
		run_program();
		compare_commits("control");
		end_test("control");
	endtask

	task automatic test_zero;
		new_test();
		prog = '{i_type(12'd123, 0, 3'b000, 0, IMM_OP), i_type(12'hff9, 0, 3'b000, 1, IMM_OP),
			r_type(7'h00, 0, 1, 3'b000, 2), EBREAK};
		expect_commit(0, 0, 123);
		expect_commit(4, 1, 64'hffff_ffff_ffff_fff9);
		expect_commit(8, 2, 64'hffff_ffff_ffff_fff9);
		load_program();
		run_program();
		compare_commits("zero");
		end_test("zero");
	endtask

	task automatic test_halt;
		new_test();
		prog = '{i_type(12'd1, 0, 3'b000, 1, IMM_OP), EBREAK, i_type(12'd2, 0, 3'b000, 2, IMM_OP)};
		expect_commit(0, 1, 1);
		load_program();
		run_program();
		compare_commits("halt ebreak");
		// a second run has to start over from pc 0
		run_program();
		compare_commits("halt restart");
		prog = '{i_type(12'd1, 0, 3'b000, 1, IMM_OP), 32'hffff_ffff,
			i_type(12'd2, 0, 3'b000, 2, IMM_OP)};
		load_program();
		run_program();
		compare_commits("halt unknown");
		end_test("halt");
	endtask

	task automatic test_sharing;
		core_pkg::u64 addr;
		core_pkg::u64 v;
		core_pkg::u64 rd_v;
		int slot;
		new_test();
		// count x2 up to 8, the jal back to the loop head commits rd 0
		prog = '{i_type(12'd8, 0, 3'b000, 1, IMM_OP), i_type(12'd0, 0, 3'b000, 2, IMM_OP),
			i_type(12'd1, 2, 3'b000, 2, IMM_OP), b_type(13'd8, 1, 2),
			j_type(21'h1ffff8, 0), EBREAK};
		expect_commit(0, 1, 8);
		expect_commit(4, 2, 0);
		for (int k = 1; k <= 8; k++) begin
			expect_commit(8, 2, k);
			if (k < 8) expect_commit(16, 0, 20);
		end
		load_program();
		run_program();
		compare_commits("sharing alone");
		fork
			run_program();
			for (int i = 0; i < 20; i++) begin
				slot = $unsigned($random(seed)) % 32;
				addr = 64'h800 + slot * 8;
				v = {$random(seed), $random(seed)};
				ext_access(1'b1, addr, v, rd_v);
				repeat (1 + $unsigned($random(seed)) % 3) @(negedge clk);
				ext_access(1'b0, addr, '0, rd_v);
				check_value("sharing readback", v, rd_v);
				@(negedge clk);
			end
		join
		compare_commits("sharing with traffic");
		end_test("sharing");
	endtask

	initial begin
		reset = 1'b1;
		run = 1'b0;
		ext_req = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_arith();
		test_memory();
		test_control();
		test_zero();
		test_halt();
		test_sharing();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
logic/core_pkg.sv
logic/regfile.sv
logic/exec_unit.sv
logic/core.sv
logic/bus_arbiter.sv
logic/sram.sv
logic/soc_top.sv
sim/tb_soc.sv
